// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - include
    files:
      - hdl/mem_pkg.sv
      - hdl/mem_req_decode.sv
      - hdl/boot_rom.sv
      - hdl/main_ram.sv
      - hdl/mem_resp_route.sv
      - hdl/mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_mem_top.sv

// ==== hdl/boot_rom.sv ====
module boot_rom (
    input  logic                clk,
    input  logic                rst_n_i,

    input  mem_pkg::ram_ireq_s  ireq_i,    // Fetch side
    input  mem_pkg::ram_ireq_s  dreq_i,    // Dbus side, reads only

    output mem_pkg::mem_rdata_s iresp_o,
    output mem_pkg::mem_rdata_s dresp_o
);

    `include "boot_image.svh"

    logic [31:0] image [mem_pkg::BMEM_DEPTH];
    logic [31:0] irdata_q;
    logic [31:0] drdata_q;
    logic        iack_q;
    logic        dack_q;

    assign image = `BOOT_IMAGE_WORDS;

    always_ff @(posedge clk) begin
        if (ireq_i.en) begin
            irdata_q <= image[ireq_i.idx[mem_pkg::BMEM_IDX_W-1:0]];
        end
        // A dbus write lands here as a plain lookup and is dropped
        if (dreq_i.en) begin
            drdata_q <= image[dreq_i.idx[mem_pkg::BMEM_IDX_W-1:0]];
        end
    end

    // One ack per accepted strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            iack_q <= 1'b0;
            dack_q <= 1'b0;
        end else begin
            iack_q <= ireq_i.en;
            dack_q <= dreq_i.en;
        end
    end

    assign iresp_o.rdata = irdata_q;
    assign iresp_o.ack   = iack_q;
    assign dresp_o.rdata = drdata_q;
    assign dresp_o.ack   = dack_q;

endmodule : boot_rom

// ==== hdl/main_ram.sv ====
module main_ram (
    input  logic                clk,
    input  logic                rst_n_i,

    input  mem_pkg::ram_ireq_s  ireq_i,    // Port A, fetch read
    input  mem_pkg::ram_dreq_s  dreq_i,    // Port B, data read/write

    output mem_pkg::mem_rdata_s iresp_o,
    output mem_pkg::mem_rdata_s dresp_o
);

    logic [31:0] mem [mem_pkg::DMEM_DEPTH];
    logic [31:0] irdata_q;
    logic [31:0] drdata_q;
    logic        iack_q;
    logic        dack_q;

    // Port B byte-lane writes
    always_ff @(posedge clk) begin
        if (dreq_i.en && dreq_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dreq_i.be[b]) begin
                    mem[dreq_i.idx][8*b +: 8] <= dreq_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Reads see the word before any same-cycle write
    always_ff @(posedge clk) begin
        if (ireq_i.en) begin
            irdata_q <= mem[ireq_i.idx];
        end
        if (dreq_i.en) begin
            drdata_q <= dreq_i.we ? 32'h0 : mem[dreq_i.idx];  // Writes return zero
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            iack_q <= 1'b0;
            dack_q <= 1'b0;
        end else begin
            iack_q <= ireq_i.en;
            dack_q <= dreq_i.en;
        end
    end

    assign iresp_o.rdata = irdata_q;
    assign iresp_o.ack   = iack_q;
    assign dresp_o.rdata = drdata_q;
    assign dresp_o.ack   = dack_q;

endmodule : main_ram

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // Boot region is selected by the top address nibble
    localparam int unsigned BMEM_SEL_HIGH   = 31;
    localparam int unsigned BMEM_SEL_LOW    = 28;
    localparam logic [3:0]  BMEM_ADDR_MATCH = 4'h1;

    localparam int unsigned BMEM_DEPTH = 16;    // Words, addr[5:2]
    localparam int unsigned DMEM_DEPTH = 1024;  // Words, addr[11:2]
    localparam int unsigned BMEM_IDX_W = 4;
    localparam int unsigned DMEM_IDX_W = 10;

    // Instruction fetch port
    typedef struct packed {
        logic [31:0] addr;
        logic        req;
    } if2mem_s;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } mem2if_s;

    // Page-table walker port
    typedef struct packed {
        logic [31:0] paddr;
        logic        req;
    } mmu2mem_s;

    // Sv32 page-table entry, v in bit 0
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } sv32_pte_s;

    // Same word seen as raw data or as a PTE
    typedef union packed {
        logic [31:0] raw;
        sv32_pte_s   pte;
    } mem_word_u;

    typedef struct packed {
        mem_word_u pte;
        logic      ack;
    } mem2mmu_s;

    // Data bus port
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        we;
        logic        req;
    } dbus2mem_s;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } mem2dbus_s;

    // Memory side requests, word indexed
    typedef struct packed {
        logic [DMEM_IDX_W-1:0] idx;
        logic [31:0]           wdata;
        logic [3:0]            be;
        logic                  we;
        logic                  en;
    } ram_dreq_s;

    typedef struct packed {
        logic [DMEM_IDX_W-1:0] idx;  // ROM uses the low BMEM_IDX_W bits
        logic                  en;
    } ram_ireq_s;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } mem_rdata_s;

endpackage : mem_pkg

// ==== hdl/mem_req_decode.sv ====
module mem_req_decode (
    input  logic               clk,
    input  logic               rst_n_i,

    input  mem_pkg::if2mem_s   if2mem_i,
    input  mem_pkg::mmu2mem_s  mmu2mem_i,
    input  mem_pkg::dbus2mem_s dbus2mem_i,
    input  logic               dmem_sel_i,     // From dbus address decoder
    input  logic               bmem_sel_i,

    // Acks of the previous cycle
    input  logic               if_busy_i,
    input  logic               mmu_busy_i,
    input  logic               dbus_busy_i,

    output mem_pkg::ram_ireq_s rom_ireq_o,
    output mem_pkg::ram_ireq_s rom_dreq_o,
    output mem_pkg::ram_ireq_s ram_ireq_o,
    output mem_pkg::ram_dreq_s ram_dreq_o,

    output logic               if_from_rom_o,
    output logic               dport_mmu_o,
    output logic               dport_dbus_o
);

    logic run_q;     // Ports open one cycle after reset release
    logic boot_hit;
    logic if_go;
    logic mmu_go;
    logic dbus_go;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign boot_hit = (if2mem_i.addr[mem_pkg::BMEM_SEL_HIGH:mem_pkg::BMEM_SEL_LOW]
                       == mem_pkg::BMEM_ADDR_MATCH);

    // A held request is not taken again while its ack is out
    assign if_go   = run_q & if2mem_i.req   & ~if_busy_i;
    assign mmu_go  = run_q & mmu2mem_i.req  & ~mmu_busy_i;
    assign dbus_go = run_q & dbus2mem_i.req & ~dbus_busy_i;

    // Fetch goes to exactly one memory
    assign rom_ireq_o.idx = {{(mem_pkg::DMEM_IDX_W - mem_pkg::BMEM_IDX_W){1'b0}},
                             if2mem_i.addr[mem_pkg::BMEM_IDX_W+1:2]};
    assign rom_ireq_o.en  = if_go & boot_hit;
    assign ram_ireq_o.idx = if2mem_i.addr[mem_pkg::DMEM_IDX_W+1:2];
    assign ram_ireq_o.en  = if_go & ~boot_hit;
    assign if_from_rom_o  = boot_hit;

    // Boot ROM data side never competes with the MMU
    assign rom_dreq_o.idx = {{(mem_pkg::DMEM_IDX_W - mem_pkg::BMEM_IDX_W){1'b0}},
                             dbus2mem_i.addr[mem_pkg::BMEM_IDX_W+1:2]};
    assign rom_dreq_o.en  = dbus_go & bmem_sel_i;

    // MMU wins the RAM data port, dbus waits
    assign dport_mmu_o  = mmu_go;
    assign dport_dbus_o = dbus_go & dmem_sel_i & ~mmu_go;

    always_comb begin
        if (dport_mmu_o) begin
            ram_dreq_o.idx   = mmu2mem_i.paddr[mem_pkg::DMEM_IDX_W+1:2];
            ram_dreq_o.wdata = '0;
            ram_dreq_o.be    = 4'hF;           // Full-word read
            ram_dreq_o.we    = 1'b0;
            ram_dreq_o.en    = 1'b1;
        end else begin
            ram_dreq_o.idx   = dbus2mem_i.addr[mem_pkg::DMEM_IDX_W+1:2];
            ram_dreq_o.wdata = dbus2mem_i.wdata;
            ram_dreq_o.be    = dbus2mem_i.be;
            ram_dreq_o.we    = dbus2mem_i.we;
            ram_dreq_o.en    = dport_dbus_o;
        end
    end

endmodule : mem_req_decode

// ==== hdl/mem_resp_route.sv ====
module mem_resp_route (
    input  logic                clk,
    input  logic                rst_n_i,

    input  mem_pkg::mem_rdata_s rom_iresp_i,
    input  mem_pkg::mem_rdata_s rom_dresp_i,
    input  mem_pkg::mem_rdata_s ram_iresp_i,
    input  mem_pkg::mem_rdata_s ram_dresp_i,

    // Grants of the current cycle
    input  logic                if_from_rom_i,
    input  logic                dport_mmu_i,
    input  logic                dport_dbus_i,

    output mem_pkg::mem2if_s    mem2if_o,
    output mem_pkg::mem2mmu_s   mem2mmu_o,
    output mem_pkg::mem2dbus_s  dmem2dbus_o,
    output mem_pkg::mem2dbus_s  bmem2dbus_o,

    output logic                if_busy_o,
    output logic                mmu_busy_o,
    output logic                dbus_busy_o
);

    logic               rom_fetch_q;  // Owner of the response now on each port
    logic               mmu_q;
    logic               dbus_q;
    mem_pkg::mem_word_u pte_word;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rom_fetch_q <= 1'b0;
            mmu_q       <= 1'b0;
            dbus_q      <= 1'b0;
        end else begin
            rom_fetch_q <= if_from_rom_i;
            mmu_q       <= dport_mmu_i;
            dbus_q      <= dport_dbus_i;
        end
    end

    // Walker reads ppn and flags through the pte view
    always_comb begin
        pte_word.raw = ram_dresp_i.rdata;
    end

    assign mem2if_o.rdata = rom_fetch_q ? rom_iresp_i.rdata : ram_iresp_i.rdata;
    assign mem2if_o.ack   = rom_fetch_q ? rom_iresp_i.ack   : ram_iresp_i.ack;

    // RAM data port is shared, only the owner sees the word
    assign mem2mmu_o.pte     = mmu_q  ? pte_word : '0;
    assign mem2mmu_o.ack     = mmu_q  & ram_dresp_i.ack;
    assign dmem2dbus_o.rdata = dbus_q ? ram_dresp_i.rdata : 32'h0;
    assign dmem2dbus_o.ack   = dbus_q & ram_dresp_i.ack;

    assign bmem2dbus_o.rdata = rom_dresp_i.rdata;
    assign bmem2dbus_o.ack   = rom_dresp_i.ack;

    assign if_busy_o   = mem2if_o.ack;
    assign mmu_busy_o  = mem2mmu_o.ack;
    assign dbus_busy_o = dmem2dbus_o.ack | bmem2dbus_o.ack;  // Either dbus target

endmodule : mem_resp_route

// ==== hdl/mem_top.sv ====
module mem_top (
    input  logic               clk,
    input  logic               rst_n_i,

    // Instruction fetch
    input  mem_pkg::if2mem_s   if2mem_i,
    output mem_pkg::mem2if_s   mem2if_o,

    // Page-table walker
    input  mem_pkg::mmu2mem_s  mmu2mem_i,
    output mem_pkg::mem2mmu_s  mem2mmu_o,

    // Data bus, selects come from the bus address decoder
    input  mem_pkg::dbus2mem_s dbus2mem_i,
    input  logic               dmem_sel_i,
    input  logic               bmem_sel_i,
    output mem_pkg::mem2dbus_s dmem2dbus_o,
    output mem_pkg::mem2dbus_s bmem2dbus_o
);

    mem_pkg::ram_ireq_s  rom_ireq;
    mem_pkg::ram_ireq_s  rom_dreq;
    mem_pkg::ram_ireq_s  ram_ireq;
    mem_pkg::ram_dreq_s  ram_dreq;
    mem_pkg::mem_rdata_s rom_iresp;
    mem_pkg::mem_rdata_s rom_dresp;
    mem_pkg::mem_rdata_s ram_iresp;
    mem_pkg::mem_rdata_s ram_dresp;

    logic                if_from_rom;
    logic                dport_mmu;
    logic                dport_dbus;
    logic                if_busy;     // Acks fed back to block repeats
    logic                mmu_busy;
    logic                dbus_busy;

    mem_req_decode u_req_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .if2mem_i      (if2mem_i),
        .mmu2mem_i     (mmu2mem_i),
        .dbus2mem_i    (dbus2mem_i),
        .dmem_sel_i    (dmem_sel_i),
        .bmem_sel_i    (bmem_sel_i),
        .if_busy_i     (if_busy),
        .mmu_busy_i    (mmu_busy),
        .dbus_busy_i   (dbus_busy),
        .rom_ireq_o    (rom_ireq),
        .rom_dreq_o    (rom_dreq),
        .ram_ireq_o    (ram_ireq),
        .ram_dreq_o    (ram_dreq),
        .if_from_rom_o (if_from_rom),
        .dport_mmu_o   (dport_mmu),
        .dport_dbus_o  (dport_dbus)
    );

    boot_rom u_boot_rom (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ireq_i  (rom_ireq),
        .dreq_i  (rom_dreq),
        .iresp_o (rom_iresp),
        .dresp_o (rom_dresp)
    );

    main_ram u_main_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ireq_i  (ram_ireq),
        .dreq_i  (ram_dreq),
        .iresp_o (ram_iresp),
        .dresp_o (ram_dresp)
    );

    mem_resp_route u_resp_route (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .rom_iresp_i   (rom_iresp),
        .rom_dresp_i   (rom_dresp),
        .ram_iresp_i   (ram_iresp),
        .ram_dresp_i   (ram_dresp),
        .if_from_rom_i (if_from_rom),
        .dport_mmu_i   (dport_mmu),
        .dport_dbus_i  (dport_dbus),
        .mem2if_o      (mem2if_o),
        .mem2mmu_o     (mem2mmu_o),
        .dmem2dbus_o   (dmem2dbus_o),
        .bmem2dbus_o   (bmem2dbus_o),
        .if_busy_o     (if_busy),
        .mmu_busy_o    (mmu_busy),
        .dbus_busy_o   (dbus_busy)
    );

endmodule : mem_top

// ==== include/boot_image.svh ====
`ifndef BOOT_IMAGE_SVH
`define BOOT_IMAGE_SVH

// Boot image, first entry at the base of the boot region
// Short entry stub, then a few constant data words at the top
`define BOOT_IMAGE_WORDS '{ \
    32'h0000_0297, \
    32'h0000_1137, \
    32'hffc1_0113, \
    32'h0000_0517, \
    32'h03c5_0513, \
    32'h0005_2583, \
    32'h00b1_2023, \
    32'h0000_02b7, \
    32'h0002_8067, \
    32'h0000_006f, \
    32'h0000_0013, \
    32'h0010_0073, \
    32'hdead_beef, \
    32'hcafe_f00d, \
    32'h1234_5678, \
    32'ha5a5_5a5a  \
}

`endif

// ==== project.f ====
+incdir+include
hdl/mem_pkg.sv
hdl/mem_req_decode.sv
hdl/boot_rom.sv
hdl/main_ram.sv
hdl/mem_resp_route.sv
hdl/mem_top.sv
verification/tb_mem_top.sv

// ==== verification/tb_mem_top.sv ====
module tb_mem_top;

    `include "boot_image.svh"

    localparam int unsigned MAX_ENTRIES = 128;
    localparam int unsigned ACK_LIMIT   = 8;     // Cycles per access before giving up
    localparam int unsigned FILL_WORDS  = 32;
    localparam int unsigned PORT_IF     = 0;
    localparam int unsigned PORT_MMU    = 1;
    localparam int unsigned PORT_DBUS   = 2;

    logic clk;
    logic rst_n;
    mem_pkg::if2mem_s   if2mem;
    mem_pkg::mem2if_s   mem2if;
    mem_pkg::mmu2mem_s  mmu2mem;
    mem_pkg::mem2mmu_s  mem2mmu;
    mem_pkg::dbus2mem_s dbus2mem;
    logic               dmem_sel;
    logic               bmem_sel;
    mem_pkg::mem2dbus_s dmem2dbus;
    mem_pkg::mem2dbus_s bmem2dbus;

    // Stimulus table, one access per row
    string       t_name  [MAX_ENTRIES];
    int unsigned t_port  [MAX_ENTRIES];
    logic [31:0] t_addr  [MAX_ENTRIES];
    logic [31:0] t_wdata [MAX_ENTRIES];
    logic [3:0]  t_be    [MAX_ENTRIES];
    logic        t_we    [MAX_ENTRIES];
    logic        t_bmem  [MAX_ENTRIES];
    logic        t_care  [MAX_ENTRIES];  // Read data is checked
    logic [31:0] t_exp   [MAX_ENTRIES];
    int unsigned n_entries;
    logic        table_ready;

    logic [31:0] ram_model  [mem_pkg::DMEM_DEPTH];
    logic [31:0] boot_words [mem_pkg::BMEM_DEPTH];
    int          seed;

    mem_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .if2mem_i    (if2mem),
        .mem2if_o    (mem2if),
        .mmu2mem_i   (mmu2mem),
        .mem2mmu_o   (mem2mmu),
        .dbus2mem_i  (dbus2mem),
        .dmem_sel_i  (dmem_sel),
        .bmem_sel_i  (bmem_sel),
        .dmem2dbus_o (dmem2dbus),
        .bmem2dbus_o (bmem2dbus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        wait (table_ready);
        repeat (n_entries * 10 + 200) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("test failed");
        $fatal(1, "watchdog");
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    function automatic mem_pkg::sv32_pte_s make_pte(input logic [11:0] ppn1,
                                                    input logic [9:0]  ppn0,
                                                    input logic [7:0]  flags);
        mem_pkg::sv32_pte_s pte;
        pte = {ppn1, ppn0, 2'b00, flags};  // Flags are d a g u x w r v
        return pte;
    endfunction

    function automatic logic port_ack(input int unsigned port, input logic bmem);
        if (port == PORT_IF)  return mem2if.ack;
        if (port == PORT_MMU) return mem2mmu.ack;
        return bmem ? bmem2dbus.ack : dmem2dbus.ack;
    endfunction

    task automatic add_entry(input string name, input int unsigned port,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, input logic we, input logic bmem);
        logic [9:0]  ridx;
        logic [3:0]  bidx;
        logic        boot_hit;
        ridx     = addr[11:2];
        bidx     = addr[5:2];
        boot_hit = (addr[31:28] == mem_pkg::BMEM_ADDR_MATCH);
        t_name[n_entries]  = name;
        t_port[n_entries]  = port;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_be[n_entries]    = be;
        t_we[n_entries]    = we;
        t_bmem[n_entries]  = bmem;
        t_care[n_entries]  = !(we && bmem);  // ROM write only needs its ack
        if (we) t_exp[n_entries] = 32'h0;
        else if (port == PORT_IF) t_exp[n_entries] = boot_hit ? boot_words[bidx] : ram_model[ridx];
        else if (port == PORT_DBUS && bmem) t_exp[n_entries] = boot_words[bidx];
        else t_exp[n_entries] = ram_model[ridx];
        if (we && !bmem) ram_model[ridx] = merge_bytes(ram_model[ridx], wdata, be);
        n_entries++;
    endtask

    task automatic build_table();
        mem_pkg::sv32_pte_s pte_leaf;
        mem_pkg::sv32_pte_s pte_ptr;
        logic [31:0]        rnd;
        pte_leaf = make_pte(12'h0ab, 10'h155, 8'b1100_1011);
        pte_ptr  = make_pte(12'h3ff, 10'h001, 8'b0000_0001);  // Pointer to next level
        add_entry("dbus_full_wr", PORT_DBUS, 32'h2000_0010, 32'h1122_3344, 4'hf, 1, 0);
        add_entry("dbus_full_rd", PORT_DBUS, 32'h2000_0010, 32'h0, 4'hf, 0, 0);
        add_entry("dbus_be_low_wr", PORT_DBUS, 32'h2000_0010, 32'haabb_ccdd, 4'b0011, 1, 0);
        add_entry("dbus_be_high_wr", PORT_DBUS, 32'h2000_0010, 32'h5566_7788, 4'b1000, 1, 0);
        add_entry("dbus_merge_rd", PORT_DBUS, 32'h2000_0010, 32'h0, 4'hf, 0, 0);
        add_entry("if_ram_merged", PORT_IF, 32'h2000_0010, 32'h0, 4'h0, 0, 0);
        add_entry("if_boot_0", PORT_IF, 32'h1000_0000, 32'h0, 4'h0, 0, 0);
        add_entry("if_boot_5", PORT_IF, 32'h1000_0014, 32'h0, 4'h0, 0, 0);
        add_entry("if_boot_15", PORT_IF, 32'h1000_003c, 32'h0, 4'h0, 0, 0);
        add_entry("dbus_rom_rd", PORT_DBUS, 32'h1000_0030, 32'h0, 4'hf, 0, 1);
        add_entry("dbus_rom_wr", PORT_DBUS, 32'h1000_0030, 32'hffff_ffff, 4'hf, 1, 1);
        add_entry("dbus_rom_rd_again", PORT_DBUS, 32'h1000_0030, 32'h0, 4'hf, 0, 1);
        add_entry("pte_leaf_wr", PORT_DBUS, 32'h2000_0200, pte_leaf, 4'hf, 1, 0);
        add_entry("pte_ptr_wr", PORT_DBUS, 32'h2000_0204, pte_ptr, 4'hf, 1, 0);
        add_entry("mmu_leaf_rd", PORT_MMU, 32'h2000_0200, 32'h0, 4'hf, 0, 0);
        add_entry("mmu_ptr_rd", PORT_MMU, 32'h2000_0204, 32'h0, 4'hf, 0, 0);
        add_entry("conc_setup_wr", PORT_DBUS, 32'h2000_0300, 32'h0bad_f00d, 4'hf, 1, 0);
        for (int k = 0; k < FILL_WORDS; k++) begin
            rnd = $random(seed);
            add_entry($sformatf("fill_wr_%0d", k), PORT_DBUS, 32'h2000_0400 + 4 * k,
                      rnd, 4'hf, 1, 0);
        end
        for (int k = 0; k < FILL_WORDS; k++) begin
            add_entry($sformatf("fill_if_rd_%0d", k), PORT_IF, 32'h2000_0400 + 4 * k,
                      32'h0, 4'h0, 0, 0);
        end
    endtask

    task automatic check_if(input string name, input mem_pkg::mem2if_s exp,
                            input mem_pkg::mem2if_s act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "fetch mismatch");
        end
    endtask

    task automatic check_dbus(input string name, input mem_pkg::mem2dbus_s exp,
                              input mem_pkg::mem2dbus_s act, input logic care);
        if (act.ack !== exp.ack || (care && act.rdata !== exp.rdata)) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "dbus mismatch");
        end
    endtask

    task automatic check_mmu(input string name, input mem_pkg::sv32_pte_s exp,
                             input mem_pkg::sv32_pte_s act);
        if (act !== exp) begin
            $display("Fail %s: expected ppn1=%h ppn0=%h flags=%b, actual ppn1=%h ppn0=%h flags=%b",
                     name, exp.ppn1, exp.ppn0, exp[7:0], act.ppn1, act.ppn0, act[7:0]);
            $display("test failed");
            $fatal(1, "mmu mismatch");
        end
    endtask

    task automatic idle_inputs();
        if2mem   = '0;
        mmu2mem  = '0;
        dbus2mem = '0;
        dmem_sel = 1'b0;
        bmem_sel = 1'b0;
    endtask

    task automatic ack_missing(input string name);
        $display("Ack never came for %s", name);
        $display("test failed");
        $fatal(1, "ack timeout");
    endtask

    task automatic run_entry(input int unsigned i);
        logic acked;
        acked = 1'b0;
        @(posedge clk);
        #2;
        if (t_port[i] == PORT_IF) begin
            if2mem.addr = t_addr[i];
            if2mem.req  = 1'b1;
        end else if (t_port[i] == PORT_MMU) begin
            mmu2mem.paddr = t_addr[i];
            mmu2mem.req   = 1'b1;
        end else begin
            dbus2mem = {t_addr[i], t_wdata[i], t_be[i], t_we[i], 1'b1};
            dmem_sel = !t_bmem[i];
            bmem_sel = t_bmem[i];
        end
        for (int c = 0; c < ACK_LIMIT && !acked; c++) begin
            @(negedge clk);                 // Registered acks are settled here
            acked = port_ack(t_port[i], t_bmem[i]);
        end
        if (!acked) ack_missing(t_name[i]);
        if (t_port[i] == PORT_IF) check_if(t_name[i], {t_exp[i], 1'b1}, mem2if);
        else if (t_port[i] == PORT_MMU) check_mmu(t_name[i], t_exp[i], mem2mmu.pte.pte);
        else check_dbus(t_name[i], {t_exp[i], 1'b1}, t_bmem[i] ? bmem2dbus : dmem2dbus, t_care[i]);
        @(posedge clk);
        #2;
        idle_inputs();
    endtask

    // MMU and dbus hit the RAM data port in the same cycle
    task automatic run_concurrent(input logic [31:0] mmu_addr, input logic [31:0] dbus_addr);
        logic        mmu_done;
        logic        dbus_done;
        int unsigned mmu_cyc;
        int unsigned dbus_cyc;
        mmu_done  = 1'b0;
        dbus_done = 1'b0;
        mmu_cyc   = 0;
        dbus_cyc  = 0;
        @(posedge clk);
        #2;
        mmu2mem  = {mmu_addr, 1'b1};
        dbus2mem = {dbus_addr, 32'h0, 4'hf, 1'b0, 1'b1};
        dmem_sel = 1'b1;
        for (int c = 1; c <= ACK_LIMIT && !(mmu_done && dbus_done); c++) begin
            @(negedge clk);
            if (!mmu_done && mem2mmu.ack) begin
                check_mmu("conc_mmu_rd", ram_model[mmu_addr[11:2]], mem2mmu.pte.pte);
                mmu_done = 1'b1;
                mmu_cyc  = c;
            end
            if (!dbus_done && dmem2dbus.ack) begin
                check_dbus("conc_dbus_rd", {ram_model[dbus_addr[11:2]], 1'b1}, dmem2dbus, 1'b1);
                dbus_done = 1'b1;
                dbus_cyc  = c;
            end
            @(posedge clk);
            #2;
            if (mmu_done) mmu2mem.req = 1'b0;  // Drop each side after its own ack
            if (dbus_done) begin
                dbus2mem.req = 1'b0;
                dmem_sel     = 1'b0;
            end
        end
        if (!mmu_done) ack_missing("conc_mmu_rd");
        if (!dbus_done) ack_missing("conc_dbus_rd");
        if (mmu_cyc > dbus_cyc) begin
            $display("MMU ack came after the dbus ack in the shared-port test");
            $display("test failed");
            $fatal(1, "arbitration order");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        table_ready = 1'b0;
        n_entries   = 0;
        seed        = 41082;
        idle_inputs();
        boot_words = `BOOT_IMAGE_WORDS;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int unsigned i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        run_concurrent(32'h2000_0200, 32'h2000_0300);
        $display("test passed");
        $finish;
    end

endmodule : tb_mem_top
